// ==== logic/ls_isa_pkg.sv ====
//##############################
// ls_isa_pkg: load/store opcodes
// and sequencer FSM states
//##############################
`default_nettype none

package ls_isa_pkg;

    // command opcodes, bit 2 marks a store in the memory group
    typedef enum logic [3:0] {
        op_iaload  = 4'h0,      // word load
        op_saload  = 4'h1,      // half load
        op_baload  = 4'h2,      // byte load
        op_iastore = 4'h4,      // word store
        op_sastore = 4'h5,      // half store
        op_bastore = 4'h6,      // byte store
        op_get     = 4'h8,      // console in, one byte
        op_put     = 4'h9       // console out, one byte
    } ls_op_t;

    // sequencer states
    typedef enum logic [1:0] {
        st_idle = 2'd0,         // waiting for queue head
        st_xfer = 2'd1,         // one byte per cycle
        st_hold = 2'd2          // result waits for a free slot
    } ls_state_t;

endpackage

`default_nettype wire

// ==== logic/ls_mem_pkg.sv ====
//##############################
// ls_mem_pkg: widths and value
// types of the memory side
//##############################
`default_nettype none

package ls_mem_pkg;

    localparam int DATA_W = 32;                     // stack word
    localparam int BYTE_W = 8;                      // memory port
    localparam int LANE_W = $clog2(DATA_W / BYTE_W); // byte index in a word

    typedef logic [DATA_W-1:0] word_t;              // tos, nos, results
    typedef logic [BYTE_W-1:0] byte_t;              // one memory byte

endpackage

`default_nettype wire

// ==== logic/ls_cmd_queue.sv ====
//##############################
// ls_cmd_queue: credit-based
// command FIFO ahead of the sequencer
//##############################
`timescale 1ns/10ps
`default_nettype none

module ls_cmd_queue #(
    parameter int CMD_DEPTH = 4
) (
    input  logic               ctl,
    input  logic               reset,
    input  logic               cmd_valid,
    input  ls_isa_pkg::ls_op_t cmd_op,
    input  ls_mem_pkg::word_t  cmd_tos,
    input  ls_mem_pkg::word_t  cmd_nos,
    input  logic               q_pop,
    output logic               cmd_credit,
    output logic               q_valid,
    output ls_isa_pkg::ls_op_t q_op,
    output ls_mem_pkg::word_t  q_tos,
    output ls_mem_pkg::word_t  q_nos
);
    import ls_isa_pkg::*;
    import ls_mem_pkg::*;

    localparam int PW = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;   // pointer width
    localparam int CW = $clog2(CMD_DEPTH + 1);                      // count width

    ls_op_t        op_mem  [CMD_DEPTH];     // entry storage
    word_t         tos_mem [CMD_DEPTH];
    word_t         nos_mem [CMD_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;                   // entries held
    logic          pop;

    // wrap at CMD_DEPTH, depth need not be a power of two
    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
        return (p == PW'(CMD_DEPTH - 1)) ? '0 : p + PW'(1);
    endfunction

    assign pop        = q_pop && q_valid;   // only a real entry leaves
    assign cmd_credit = pop;                // slot freed, credit back to sender
    assign q_valid    = (count != '0);
    assign q_op       = op_mem[rd_ptr];     // head of queue
    assign q_tos      = tos_mem[rd_ptr];
    assign q_nos      = nos_mem[rd_ptr];

    always_ff @(posedge ctl) begin
        if (cmd_valid) begin
            op_mem[wr_ptr]  <= cmd_op;
            tos_mem[wr_ptr] <= cmd_tos;
            nos_mem[wr_ptr] <= cmd_nos;
        end
    end

    always_ff @(posedge ctl) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) wr_ptr <= ptr_next(wr_ptr);
            if (pop)       rd_ptr <= ptr_next(rd_ptr);
            case ({cmd_valid, pop})
                2'b10:   count <= count + CW'(1);   // push only
                2'b01:   count <= count - CW'(1);   // pop only
                default: count <= count;            // both or none
            endcase
        end
    end

    // sender pushed without a credit
    a_no_overflow: assert property (@(posedge ctl) disable iff (reset)
        cmd_valid |-> (count != CW'(CMD_DEPTH)))
        else $error("command queue overflow, sender credit violation");

endmodule

`default_nettype wire

// ==== logic/ls_unit.sv ====
//##############################
// ls_unit: byte-serial load/store
// sequencer over a byte-wide memory
//##############################
`timescale 1ns/10ps
`default_nettype none

module ls_unit #(
    parameter int ASZ  = 12,
    parameter int TIB  = 'h100,
    parameter int OBUF = 'h140
) (
    input  logic               ctl,
    input  logic               reset,
    input  logic               q_valid,
    input  ls_isa_pkg::ls_op_t q_op,
    input  ls_mem_pkg::word_t  q_tos,
    input  ls_mem_pkg::word_t  q_nos,
    input  ls_mem_pkg::byte_t  mem_rdata,
    input  logic               res_ready,
    output logic               q_pop,
    output logic [ASZ-1:0]     mem_addr,
    output logic               mem_we,
    output ls_mem_pkg::byte_t  mem_wdata,
    output logic               res_valid,
    output ls_mem_pkg::word_t  res_data
);
    import ls_isa_pkg::*;
    import ls_mem_pkg::*;

    ls_state_t         state;
    logic [LANE_W-1:0] phase;       // byte count within the command
    logic [LANE_W-1:0] last_q;      // bytes - 1, latched at pop
    logic [LANE_W-1:0] sel;         // byte of tos being written
    logic              load_q;      // load or get in flight
    word_t             tos_q;       // store data
    word_t             acc;         // load result shifter
    logic [ASZ-1:0]    addr_q;      // steps by one per byte
    logic [ASZ-1:0]    ibuf;        // console input pointer
    logic [ASZ-1:0]    obuf;        // console output pointer
    logic              take;

    // decode of the queue head
    logic              dec_load;
    logic [LANE_W-1:0] dec_last;
    logic [ASZ-1:0]    dec_base;
    logic              dec_in;      // get bumps ibuf
    logic              dec_out;     // put bumps obuf

    always_comb begin
        dec_load = 1'b1;
        dec_last = '0;
        dec_base = q_tos[ASZ-1:0];  // loads address by tos
        dec_in   = 1'b0;
        dec_out  = 1'b0;
        case (q_op)
            op_iaload: dec_last = LANE_W'(3);
            op_saload: dec_last = LANE_W'(1);
            op_baload: dec_last = '0;
            op_iastore: begin
                dec_load = 1'b0;
                dec_last = LANE_W'(3);
                dec_base = q_nos[ASZ-1:0];  // stores address by nos
            end
            op_sastore: begin
                dec_load = 1'b0;
                dec_last = LANE_W'(1);
                dec_base = q_nos[ASZ-1:0];
            end
            op_bastore: begin
                dec_load = 1'b0;
                dec_base = q_nos[ASZ-1:0];
            end
            op_get: begin
                dec_base = ibuf;
                dec_in   = 1'b1;
            end
            op_put: begin
                dec_load = 1'b0;
                dec_base = obuf;
                dec_out  = 1'b1;
            end
            default: dec_load = 1'b1;       // unused codes act as byte load
        endcase
    end

    assign take      = (state == st_idle) && q_valid;
    assign q_pop     = take;
    assign sel       = last_q - phase;                    // highest byte first
    assign mem_addr  = (state == st_idle) ? dec_base : addr_q; // first read at pop
    assign mem_we    = (state == st_xfer) && !load_q;
    assign mem_wdata = tos_q[sel*BYTE_W +: BYTE_W];
    assign res_data  = acc;

    // per-command payload
    always_ff @(posedge ctl) begin
        if (take) begin
            tos_q  <= q_tos;
            load_q <= dec_load;
            last_q <= dec_last;
            acc    <= '0;                                   // zero-extend
            addr_q <= dec_load ? dec_base + ASZ'(1) : dec_base; // loads run one ahead
        end else if (state == st_xfer) begin
            addr_q <= addr_q + ASZ'(1);
            if (load_q) acc <= {acc[DATA_W-BYTE_W-1:0], mem_rdata}; // merge at bottom
        end
    end

    // FSM, buffer pointers and result strobe
    always_ff @(posedge ctl) begin
        if (reset) begin
            state     <= st_idle;
            phase     <= '0;
            res_valid <= 1'b0;
            ibuf      <= ASZ'(TIB);
            obuf      <= ASZ'(OBUF);
        end else begin
            res_valid <= 1'b0;                              // one-cycle pulse
            case (state)
                st_idle: begin
                    if (take) begin
                        state <= st_xfer;
                        phase <= '0;
                        if (dec_in)  ibuf <= ibuf + ASZ'(1);
                        if (dec_out) obuf <= obuf + ASZ'(1);
                    end
                end
                st_xfer: begin
                    if (phase != last_q) begin
                        phase <= phase + LANE_W'(1);
                    end else if (!load_q) begin
                        state <= st_idle;                   // last write done
                    end else if (res_ready) begin
                        res_valid <= 1'b1;                  // last byte merged now
                        state     <= st_idle;
                    end else begin
                        state <= st_hold;                   // no slot downstream
                    end
                end
                st_hold: begin
                    if (res_ready) begin
                        res_valid <= 1'b1;
                        state     <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_no_idle_write: assert property (@(posedge ctl) disable iff (reset)
        (state == st_idle) |-> !mem_we)
        else $error("memory write while sequencer idle");

    // ready was sampled a cycle earlier, must still hold at the strobe
    a_res_has_slot: assert property (@(posedge ctl) disable iff (reset)
        res_valid |-> res_ready)
        else $error("result issued without a free result slot");

endmodule

`default_nettype wire

// ==== logic/byte_ram.sv ====
//##############################
// byte_ram: single-port byte memory,
// registered read, write-first
//##############################
`timescale 1ns/10ps
`default_nettype none

module byte_ram #(
    parameter int ASZ = 12
) (
    input  logic              ctl,
    input  logic [ASZ-1:0]    mem_addr,
    input  logic              mem_we,
    input  ls_mem_pkg::byte_t mem_wdata,
    output ls_mem_pkg::byte_t mem_rdata
);
    import ls_mem_pkg::*;

    byte_t mem [2**ASZ];                    // whole address space

    always_ff @(posedge ctl) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
            mem_rdata     <= mem_wdata;     // new byte on write
        end else begin
            mem_rdata     <= mem[mem_addr]; // data one cycle after address
        end
    end

endmodule

`default_nettype wire

// ==== logic/ls_result_stage.sv ====
//##############################
// ls_result_stage: output register
// and consumer credit counter
//##############################
`timescale 1ns/10ps
`default_nettype none

module ls_result_stage #(
    parameter int RSP_CREDITS = 2
) (
    input  logic              ctl,
    input  logic              reset,
    input  logic              res_valid,
    input  ls_mem_pkg::word_t res_data,
    input  logic              rsp_credit,
    output logic              res_ready,
    output logic              rsp_valid,
    output ls_mem_pkg::word_t rsp_data
);

    localparam int CW = $clog2(RSP_CREDITS + 1);

    logic [CW-1:0] credits;                 // free slots at the consumer

    // a slot left and nothing leaving this cycle
    assign res_ready = (credits != '0) && !rsp_valid;

    always_ff @(posedge ctl) begin
        if (reset) begin
            rsp_valid <= 1'b0;
            credits   <= CW'(RSP_CREDITS);
        end else begin
            rsp_valid <= res_valid;                 // one cycle behind
            case ({rsp_valid, rsp_credit})
                2'b10:   credits <= credits - CW'(1);   // slot taken
                2'b01:   credits <= credits + CW'(1);   // slot freed
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge ctl) begin
        if (res_valid) rsp_data <= res_data;
    end

    // consumer returned more credits than it owns
    a_credit_bound: assert property (@(posedge ctl) disable iff (reset)
        credits <= CW'(RSP_CREDITS))
        else $error("response credit count above RSP_CREDITS");

endmodule

`default_nettype wire

// ==== logic/ls_top.sv ====
//##############################
// ls_top: load/store path, queue,
// sequencer, memory, result stage
//##############################
`timescale 1ns/10ps
`default_nettype none

module ls_top #(
    parameter int ASZ         = 12,
    parameter int CMD_DEPTH   = 4,
    parameter int RSP_CREDITS = 2,
    parameter int TIB         = 'h100,
    parameter int OBUF        = 'h140
) (
    input  logic               ctl,
    input  logic               reset,
    input  logic               cmd_valid,
    input  ls_isa_pkg::ls_op_t cmd_op,
    input  ls_mem_pkg::word_t  cmd_tos,
    input  ls_mem_pkg::word_t  cmd_nos,
    input  logic               rsp_credit,
    output logic               cmd_credit,
    output logic               rsp_valid,
    output ls_mem_pkg::word_t  rsp_data
);
    import ls_isa_pkg::*;
    import ls_mem_pkg::*;

    logic           q_valid;        // queue head
    ls_op_t         q_op;
    word_t          q_tos;
    word_t          q_nos;
    logic           q_pop;
    logic [ASZ-1:0] mem_addr;       // memory port
    logic           mem_we;
    byte_t          mem_wdata;
    byte_t          mem_rdata;
    logic           res_ready;      // result handoff
    logic           res_valid;
    word_t          res_data;

    ls_cmd_queue #(
        .CMD_DEPTH (CMD_DEPTH)
    ) u_queue (
        .ctl        (ctl),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_tos    (cmd_tos),
        .cmd_nos    (cmd_nos),
        .q_pop      (q_pop),
        .cmd_credit (cmd_credit),
        .q_valid    (q_valid),
        .q_op       (q_op),
        .q_tos      (q_tos),
        .q_nos      (q_nos)
    );

    ls_unit #(
        .ASZ  (ASZ),
        .TIB  (TIB),
        .OBUF (OBUF)
    ) u_unit (
        .ctl       (ctl),
        .reset     (reset),
        .q_valid   (q_valid),
        .q_op      (q_op),
        .q_tos     (q_tos),
        .q_nos     (q_nos),
        .mem_rdata (mem_rdata),
        .res_ready (res_ready),
        .q_pop     (q_pop),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    byte_ram #(
        .ASZ (ASZ)
    ) u_ram (
        .ctl       (ctl),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    ls_result_stage #(
        .RSP_CREDITS (RSP_CREDITS)
    ) u_result (
        .ctl        (ctl),
        .reset      (reset),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .rsp_credit (rsp_credit),
        .res_ready  (res_ready),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

endmodule

`default_nettype wire

// ==== verification/ls_tb.sv ====
//##############################
// ls_tb drives ls_top with directed
// tests of the load/store path
//##############################
`timescale 1ns/10ps
`default_nettype none

module ls_tb;
    import ls_isa_pkg::*;
    import ls_mem_pkg::*;

    localparam int CMD_DEPTH   = 4;         // ls_top defaults
    localparam int RSP_CREDITS = 2;
    localparam int TIB         = 'h100;
    localparam int OBUF        = 'h140;
    localparam int LIMIT       = 2000;      // cycle budget for all tests

    logic   ctl;
    logic   reset;
    logic   cmd_valid;
    ls_op_t cmd_op;
    word_t  cmd_tos;
    word_t  cmd_nos;
    logic   rsp_credit;
    logic   cmd_credit;
    logic   rsp_valid;
    word_t  rsp_data;

    int          sent;                      // commands pushed by the sender
    int          returned;                  // cmd_credit pulses seen
    int          cycles;
    word_t       rsp_q[$];                  // responses not yet consumed
    logic [31:0] lfsr;

    ls_top u_dut (
        .ctl        (ctl),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_tos    (cmd_tos),
        .cmd_nos    (cmd_nos),
        .rsp_credit (rsp_credit),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    always #50 ctl = ~ctl;                  // 100 ns period

    // values of the cycle that just closed
    always @(posedge ctl) begin
        if (!reset) begin
            if (cmd_credit) returned = returned + 1;
            if (rsp_valid)  rsp_q.push_back(rsp_data);
        end
    end

    always @(posedge ctl) begin
        cycles = cycles + 1;
        if (cycles == LIMIT) begin
            $display("Checks failed");
            $fatal(1, "simulation timed out after %0d cycles", LIMIT);
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int sender_credits();
        return CMD_DEPTH - sent + returned;
    endfunction

    task automatic lfsr_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);         // one step per bit
            v    = {v[DATA_W-2:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // called and left just after a falling edge
    task automatic send_cmd(input ls_op_t op, input word_t tos, input word_t nos);
        while (sender_credits() == 0) @(negedge ctl);   // wait for a credit
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_tos   = tos;
        cmd_nos   = nos;
        sent      = sent + 1;
        @(negedge ctl);
        cmd_valid = 1'b0;
    endtask

    task automatic collect_rsp(output word_t data);
        while (rsp_q.size() == 0) @(negedge ctl);
        data       = rsp_q.pop_front();
        rsp_credit = 1'b1;                  // consumer frees the slot
        @(negedge ctl);
        rsp_credit = 1'b0;
    endtask

    task automatic load_and_check(input ls_op_t op, input word_t addr, input word_t exp,
                                  input string name);
        word_t got;
        send_cmd(op, addr, 32'h0);
        collect_rsp(got);
        check_value(name, got, exp);
    endtask

    task automatic word_round_trip();
        word_t w;
        w = 32'hc3a5_17e9;
        send_cmd(op_iastore, w, 32'h020);   // store address in nos
        load_and_check(op_iaload, 32'h020, w, "word load");
        load_and_check(op_saload, 32'h020, {16'h0, w[31:16]}, "half load");
        for (int i = 0; i < 4; i++) begin
            load_and_check(op_baload, 32'h020 + 32'(i), {24'h0, w[31-8*i -: 8]},
                           "byte load");    // msb at the lowest address
        end
    endtask

    task automatic partial_stores();
        word_t w;
        word_t h;
        word_t b;
        w = 32'h0102_0304;
        h = 32'hffff_9abc;
        b = 32'h1234_56de;
        send_cmd(op_iastore, w, 32'h040);
        send_cmd(op_sastore, h, 32'h042);
        send_cmd(op_bastore, b, 32'h040);
        load_and_check(op_iaload, 32'h040, {b[7:0], w[23:16], h[15:0]}, "merged word");
    endtask

    task automatic console_input();
        word_t v[3];
        v[0] = 32'hdead_be5a;
        v[1] = 32'h0000_0081;
        v[2] = 32'h7777_7703;
        for (int i = 0; i < 3; i++) send_cmd(op_bastore, v[i], 32'(TIB + i));
        for (int i = 0; i < 3; i++) begin
            load_and_check(op_get, 32'h0, {24'h0, v[i][7:0]}, "get byte");
        end
    endtask

    task automatic console_output();
        word_t a;
        word_t b;
        a = 32'h1111_22c7;
        b = 32'h0bad_f00d;
        send_cmd(op_put, a, 32'h0);
        send_cmd(op_put, b, 32'h0);
        load_and_check(op_baload, 32'(OBUF), {24'h0, a[7:0]}, "put byte 0");
        load_and_check(op_baload, 32'(OBUF + 1), {24'h0, b[7:0]}, "put byte 1");
    endtask

    task automatic back_pressure();
        word_t w0;
        word_t w1;
        word_t got;
        int    ret0;
        w0 = 32'h8899_aabb;
        w1 = 32'hccdd_eeff;
        send_cmd(op_iastore, w0, 32'h200);
        send_cmd(op_iastore, w1, 32'h204);
        for (int i = 0; i < 5; i++) send_cmd(op_baload, 32'h200 + 32'(i), 32'h0);
        while (rsp_q.size() < RSP_CREDITS) @(negedge ctl);
        ret0 = returned;
        repeat (20) @(negedge ctl);         // nothing may move now
        check_value("rsp count", 32'(rsp_q.size()), 32'(RSP_CREDITS));
        check_value("cmd_credit returns", 32'(returned), 32'(ret0));
        // one load held in the sequencer
        check_value("queued commands", 32'(sent - returned), 32'(5 - RSP_CREDITS - 1));
        for (int i = 0; i < 5; i++) begin
            collect_rsp(got);
            if (i < 4) check_value("stalled byte", got, {24'h0, w0[31-8*i -: 8]});
            else       check_value("stalled byte", got, {24'h0, w1[31:24]});
        end
        check_value("sender credits", 32'(sender_credits()), 32'(CMD_DEPTH));
    endtask

    task automatic random_words();
        logic  used[256];
        word_t addr[8];
        word_t data[8];
        word_t v;
        for (int i = 0; i < 256; i++) used[i] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            lfsr_bits(8, v);
            while (used[v[7:0]]) lfsr_bits(8, v);   // keep slots distinct
            used[v[7:0]] = 1'b1;
            addr[i] = {22'h0, v[7:0], 2'b00};       // word aligned
            lfsr_bits(32, data[i]);
            send_cmd(op_iastore, data[i], addr[i]);
        end
        for (int i = 0; i < 8; i++) load_and_check(op_iaload, addr[i], data[i], "random word");
    endtask

    initial begin
        ctl        = 1'b0;
        reset      = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = op_baload;
        cmd_tos    = '0;
        cmd_nos    = '0;
        rsp_credit = 1'b0;
        sent       = 0;
        returned   = 0;
        cycles     = 0;
        lfsr       = 32'hce1f_451d;
        repeat (3) @(negedge ctl);
        reset = 1'b0;

        word_round_trip();
        partial_stores();
        console_input();
        console_output();
        back_pressure();
        random_words();
        repeat (10) @(negedge ctl);         // stores must not answer
        check_value("leftover responses", 32'(rsp_q.size()), 32'h0);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/ls_isa_pkg.sv
logic/ls_mem_pkg.sv
logic/ls_cmd_queue.sv
logic/ls_unit.sv
logic/byte_ram.sv
logic/ls_result_stage.sv
logic/ls_top.sv
verification/ls_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the load/store testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ls_tb \
    -f all.f \
    -o ls_sim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/ls_sim
